// ==== source/core_pkg.sv ====
// ================================================
// Shared types for core stage 2
// Opcode, FSM state and halt-cause enums
// Instruction, data-port and CSR link structs
// ================================================

package core_pkg;

    // Reduced RV32I opcode set handled by stage 2
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_EBREAK,
        OP_ILLEGAL
    } op_e;

    // Stage FSM states
    typedef enum logic [2:0] {
        INIT,
        HALT,
        FETCH_NEXT,
        WAIT_ON_L1DCACHE,
        FINISH_CURRENT_AND_FETCH_NEXT
    } state_e;

    // Why the stage stopped
    typedef enum logic [1:0] {
        NONE,
        EBREAK,
        ILLEGAL,
        USER
    } halt_cause_e;

    // Decoded instruction, fixed register fields plus selected immediate
    typedef struct packed {
        op_e         op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
    } decoded_t;

    // Stage 1 to stage 2, one word per held credit
    typedef struct packed {
        logic        valid;
        logic [31:0] word;
    } instr_link_t;

    // Data request, addr counts 32-bit words
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dmem_req_t;

    // One response per request, reads and writes alike
    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } dmem_rsp_t;

    // Outside configuration write
    typedef struct packed {
        logic valid;
        logic run;
        logic clear_halt;
    } csr_cfg_t;

    // Status seen from outside
    typedef struct packed {
        logic        halted;
        halt_cause_e cause;
        logic [31:0] retired;
    } csr_status_t;

endpackage : core_pkg

// ==== source/core_decode.sv ====
// ================================================
// Instruction decoder for core stage 2
// Maps opcode/funct fields onto op_e
// Selects the I, S or U immediate
// ================================================

`timescale 1ns/1ps

module core_decode (
    input  logic [31:0]        instr,
    output core_pkg::decoded_t dec
);

    import core_pkg::*;

    // Base opcode field values
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Only one SYSTEM encoding is accepted
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_u;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Sign-extended immediates, all formats computed in parallel
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};

    // Register fields sit at fixed positions in every format
    assign dec.rd  = instr[11:7];
    assign dec.rs1 = instr[19:15];
    assign dec.rs2 = instr[24:20];

    always_comb begin
        dec.op  = OP_ILLEGAL;
        dec.imm = '0;
        unique case (opcode)
            OPC_OP: begin
                // R-type, funct7 picks ADD or SUB
                unique case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec.op = OP_ADD;
                    {7'b0100000, 3'b000}: dec.op = OP_SUB;
                    {7'b0000000, 3'b111}: dec.op = OP_AND;
                    {7'b0000000, 3'b110}: dec.op = OP_OR;
                    {7'b0000000, 3'b100}: dec.op = OP_XOR;
                    default:              dec.op = OP_ILLEGAL;
                endcase
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) dec.op = OP_ADDI;
                dec.imm = imm_i;
            end
            OPC_LUI: begin
                dec.op  = OP_LUI;
                dec.imm = imm_u;
            end
            OPC_LOAD: begin
                // Word loads only
                if (funct3 == 3'b010) dec.op = OP_LW;
                dec.imm = imm_i;
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) dec.op = OP_SW;
                dec.imm = imm_s;
            end
            OPC_SYSTEM: begin
                if (instr == EBREAK_WORD) dec.op = OP_EBREAK;
            end
            default: dec.op = OP_ILLEGAL;
        endcase
    end

endmodule : core_decode

// ==== source/core_regfile.sv ====
// ================================================
// 32 x 32-bit register file
// Two async read ports, one sync write port
// ================================================

`timescale 1ns/1ps

module core_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        we,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data
);

    logic [31:0] regs [32];

    // Asynchronous reads
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // Whole array clears on reset and x0 never takes a write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 holds zero at every clock, writes aimed at it included
    a_x0_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        regs[0] == '0
    ) else $error("x0 holds a nonzero value");

endmodule : core_regfile

// ==== source/core_alu.sv ====
// ================================================
// ALU for core stage 2
// Register ops, ADDI, LUI pass-through
// Byte address for LW and SW
// ================================================

`timescale 1ns/1ps

module core_alu (
    input  core_pkg::decoded_t dec,
    input  logic [31:0]        rs1_data,
    input  logic [31:0]        rs2_data,
    output logic [31:0]        result
);

    import core_pkg::*;

    logic [31:0] rs1_plus_imm;

    // Shared adder for ADDI and the load/store address
    assign rs1_plus_imm = rs1_data + dec.imm;

    always_comb begin
        unique case (dec.op)
            OP_ADD:  result = rs1_data + rs2_data;
            OP_SUB:  result = rs1_data - rs2_data;
            OP_AND:  result = rs1_data & rs2_data;
            OP_OR:   result = rs1_data | rs2_data;
            OP_XOR:  result = rs1_data ^ rs2_data;
            OP_ADDI: result = rs1_plus_imm;
            // Upper immediate already shifted by decode
            OP_LUI:  result = dec.imm;
            // Byte address, control drops the low two bits
            OP_LW,
            OP_SW:   result = rs1_plus_imm;
            // EBREAK and illegal produce nothing useful
            default: result = '0;
        endcase
    end

endmodule : core_alu

// ==== source/core_s2_control.sv ====
// ================================================
// Stage 2 control FSM
// Instruction latch, data-credit counter
// Mealy outputs for write-back, credits and requests
// ================================================

`timescale 1ns/1ps

module core_s2_control #(
    parameter int DMEM_CREDITS = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  core_pkg::instr_link_t  instr_in,
    output logic                   instr_credit,
    input  core_pkg::decoded_t     dec,
    input  logic [31:0]            alu_result,
    input  logic [31:0]            rs2_data,
    output core_pkg::dmem_req_t    dmem_req,
    input  core_pkg::dmem_rsp_t    dmem_rsp,
    input  logic                   dmem_credit,
    input  logic                   run,
    input  logic                   halt_req,
    output logic                   rd_we,
    output logic [31:0]            rd_data,
    output logic [31:0]            instr_word,
    output logic                   retire,
    output logic                   halt_event,
    output core_pkg::halt_cause_e  halt_cause
);

    import core_pkg::*;

    localparam int CW = $clog2(DMEM_CREDITS + 1);

    state_e      state, next_state;
    logic [31:0] instr_q;
    logic        instr_pend;
    logic        instr_owed;
    logic        accept;
    logic [CW-1:0] credits;
    logic        req_sent;
    logic        issue;
    logic [31:0] load_q;

    // Word may arrive while run is low, so it is held until accepted
    assign accept = (state == FETCH_NEXT) && !halt_req && run &&
                    (instr_pend || instr_in.valid);

    // Decode sees the arriving word directly, else the held one
    assign instr_word = instr_in.valid ? instr_in.word : instr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= INIT;
            instr_pend <= 1'b0;
            instr_owed <= 1'b0;
            req_sent   <= 1'b0;
            credits    <= CW'(DMEM_CREDITS);
        end else begin
            state <= next_state;
            // Pending word flag, dropped on accept or halt
            if (instr_in.valid && !accept && state == FETCH_NEXT) begin
                instr_pend <= 1'b1;
            end else if (accept || state == INIT || state == HALT) begin
                instr_pend <= 1'b0;
            end
            // Tracks a credit handed out but not yet used
            if (instr_credit) begin
                instr_owed <= 1'b1;
            end else if (instr_in.valid) begin
                instr_owed <= 1'b0;
            end
            // One request per memory instruction
            if (issue) begin
                req_sent <= 1'b1;
            end else if (state != WAIT_ON_L1DCACHE) begin
                req_sent <= 1'b0;
            end
            unique case ({issue, dmem_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (instr_in.valid) instr_q <= instr_in.word;
        if (dmem_rsp.valid) load_q <= dmem_rsp.rdata;
    end

    always_comb begin
        next_state = state;
        halt_event = 1'b0;
        halt_cause = NONE;
        unique case (state)
            INIT: next_state = FETCH_NEXT;
            // CSR holds halt_req high until clear_halt
            HALT: if (!halt_req) next_state = INIT;
            FETCH_NEXT: begin
                if (halt_req) begin
                    next_state = HALT;
                    halt_event = 1'b1;
                    halt_cause = USER;
                end else if (accept) begin
                    unique case (dec.op)
                        OP_EBREAK: begin
                            next_state = HALT;
                            halt_event = 1'b1;
                            halt_cause = EBREAK;
                        end
                        OP_ILLEGAL: begin
                            next_state = HALT;
                            halt_event = 1'b1;
                            halt_cause = ILLEGAL;
                        end
                        OP_LW, OP_SW: next_state = WAIT_ON_L1DCACHE;
                        default:      next_state = FINISH_CURRENT_AND_FETCH_NEXT;
                    endcase
                end
            end
            // Response pulse ends the wait
            WAIT_ON_L1DCACHE: begin
                if (dmem_rsp.valid) next_state = FINISH_CURRENT_AND_FETCH_NEXT;
            end
            FINISH_CURRENT_AND_FETCH_NEXT: next_state = FETCH_NEXT;
            default: next_state = HALT;
        endcase
    end

    // Mealy outputs
    assign issue = (state == WAIT_ON_L1DCACHE) && !req_sent && (credits != '0);

    assign dmem_req.valid = issue;
    assign dmem_req.write = (dec.op == OP_SW);
    assign dmem_req.addr  = {2'b00, alu_result[31:2]};
    assign dmem_req.wdata = rs2_data;

    assign instr_credit = (state == INIT) || (state == FINISH_CURRENT_AND_FETCH_NEXT);
    assign retire       = (state == FINISH_CURRENT_AND_FETCH_NEXT);
    assign rd_we        = (state == FINISH_CURRENT_AND_FETCH_NEXT) && (dec.op != OP_SW);
    assign rd_data      = (dec.op == OP_LW) ? load_q : alu_result;

    // Memory never returns more credits than were spent
    a_credit_max: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dmem_credit && !issue) |-> (credits < CW'(DMEM_CREDITS))
    ) else $error("data credit returned with counter full");

    // Stage 1 only sends against a credit it holds
    a_instr_credit: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_in.valid |-> instr_owed
    ) else $error("instruction arrived without a credit");

endmodule : core_s2_control

// ==== source/core_csr_block.sv ====
// ================================================
// Control/status registers for core stage 2
// Run enable, halt flag and cause, retired count
// ================================================

`timescale 1ns/1ps

module core_csr_block (
    input  logic                  clk,
    input  logic                  rst_n,
    input  core_pkg::csr_cfg_t    cfg,
    input  logic                  retire,
    input  logic                  halt_event,
    input  core_pkg::halt_cause_e halt_cause,
    output logic                  run,
    output logic                  halt_req,
    output core_pkg::csr_status_t status
);

    import core_pkg::*;

    logic        run_q;
    logic        stop_pend;
    logic        halted_q;
    halt_cause_e cause_q;
    logic [31:0] retired_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q     <= 1'b0;
            stop_pend <= 1'b0;
            halted_q  <= 1'b0;
            cause_q   <= NONE;
            retired_q <= '0;
        end else begin
            if (cfg.valid) begin
                run_q <= cfg.run;
            end
            // Falling run requests a user halt at the next fetch
            if (halt_event) begin
                stop_pend <= 1'b0;
            end else if (cfg.valid && run_q && !cfg.run) begin
                stop_pend <= 1'b1;
            end
            if (halt_event) begin
                halted_q <= 1'b1;
                cause_q  <= halt_cause;
            end else if (cfg.valid && cfg.clear_halt && halted_q) begin
                halted_q <= 1'b0;
                cause_q  <= NONE;
            end
            if (retire) retired_q <= retired_q + 32'd1;
        end
    end

    assign run = run_q;
    // Also held while halted, control leaves HALT once this drops
    assign halt_req = stop_pend || halted_q;

    assign status.halted  = halted_q;
    assign status.cause   = cause_q;
    assign status.retired = retired_q;

    // FSM never finishes an instruction once halted
    a_no_retire_halted: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted_q |-> !retire
    ) else $error("retire pulsed while halted");

endmodule : core_csr_block

// ==== source/core_s2_top.sv ====
// ================================================
// Core stage 2 top level
// Decode, register file, ALU, control FSM, CSRs
// ================================================

`timescale 1ns/1ps

module core_s2_top #(
    parameter int DMEM_CREDITS = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  core_pkg::instr_link_t instr_in,
    output logic                  instr_credit,
    output core_pkg::dmem_req_t   dmem_req,
    input  core_pkg::dmem_rsp_t   dmem_rsp,
    input  logic                  dmem_credit,
    input  core_pkg::csr_cfg_t    cfg,
    output core_pkg::csr_status_t status
);

    import core_pkg::*;

    decoded_t    dec;
    logic [31:0] instr_word;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] alu_result;
    logic        rd_we;
    logic [31:0] rd_data;
    logic        run;
    logic        halt_req;
    logic        retire;
    logic        halt_event;
    halt_cause_e halt_cause;

    // Decode follows the word chosen by control
    core_decode core_decode_i (
        .instr (instr_word),
        .dec   (dec)
    );

    // Register fields come straight from decode
    core_regfile core_regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (dec.rs1),
        .rs2_addr (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rd_we),
        .wr_addr  (dec.rd),
        .wr_data  (rd_data)
    );

    core_alu core_alu_i (
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result)
    );

    core_s2_control #(
        .DMEM_CREDITS (DMEM_CREDITS)
    ) core_s2_control_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_in     (instr_in),
        .instr_credit (instr_credit),
        .dec          (dec),
        .alu_result   (alu_result),
        .rs2_data     (rs2_data),
        .dmem_req     (dmem_req),
        .dmem_rsp     (dmem_rsp),
        .dmem_credit  (dmem_credit),
        .run          (run),
        .halt_req     (halt_req),
        .rd_we        (rd_we),
        .rd_data      (rd_data),
        .instr_word   (instr_word),
        .retire       (retire),
        .halt_event   (halt_event),
        .halt_cause   (halt_cause)
    );

    core_csr_block core_csr_block_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .retire     (retire),
        .halt_event (halt_event),
        .halt_cause (halt_cause),
        .run        (run),
        .halt_req   (halt_req),
        .status     (status)
    );

endmodule : core_s2_top

// ==== dv/core_s2_dmem_model.sv ====
// ================================================
// Credit-based L1 data memory model
// Random response delay, credit returned with
// or after the response
// ================================================

`timescale 1ns/1ps

module core_s2_dmem_model (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::dmem_req_t dmem_req,
    output core_pkg::dmem_rsp_t dmem_rsp,
    output logic                dmem_credit
);

    import core_pkg::*;

    logic [31:0] mem [256];
    logic [31:0] rdata_q [$];
    int          rsp_due [$];
    int          credit_due [$];
    int          cyc;

    // Fill pattern carries the whole word index
    initial begin
        dmem_rsp    = '0;
        dmem_credit = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hbad0_0000 | 32'(i);
        end
    end

    // Requests are taken at the rising edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc = 0;
            rdata_q.delete();
            rsp_due.delete();
        end else begin
            cyc = cyc + 1;
            if (dmem_req.valid) begin
                if (dmem_req.write) begin
                    mem[dmem_req.addr[7:0]] = dmem_req.wdata;
                    rdata_q.push_back('0);
                end else begin
                    rdata_q.push_back(mem[dmem_req.addr[7:0]]);
                end
                // Zero delay answers in the very next cycle
                rsp_due.push_back(cyc + int'($urandom_range(3, 0)));
            end
        end
    end

    // Responses and credits change on the falling edge
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_rsp    = '0;
            dmem_credit = 1'b0;
            credit_due.delete();
        end else begin
            dmem_rsp    = '0;
            dmem_credit = 1'b0;
            if (rsp_due.size() > 0 && cyc >= rsp_due[0]) begin
                dmem_rsp.valid = 1'b1;
                dmem_rsp.rdata = rdata_q.pop_front();
                void'(rsp_due.pop_front());
                // Late credits let a one-credit port stall
                credit_due.push_back(cyc + int'($urandom_range(5, 0)));
            end
            // At most one credit pulse per cycle
            if (credit_due.size() > 0 && cyc >= credit_due[0]) begin
                dmem_credit = 1'b1;
                void'(credit_due.pop_front());
            end
        end
    end

endmodule : core_s2_dmem_model

// ==== dv/core_s2_tb.sv ====
// ================================================
// Testbench for core stage 2
// Clock, reset, instruction programs, shadow
// register and memory model, request assertions
// ================================================

`timescale 1ns/1ps

module core_s2_tb #(
    parameter int DMEM_CREDITS = 2
);

    import core_pkg::*;

    localparam logic [31:0] SEED        = 32'h5f3f3fdc;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
    localparam int          WAIT_LIMIT  = 200;

    logic        clk;
    logic        rst_n;
    instr_link_t instr_in;
    logic        instr_credit;
    dmem_req_t   dmem_req;
    dmem_rsp_t   dmem_rsp;
    logic        dmem_credit;
    csr_cfg_t    cfg;
    csr_status_t status;

    // Shadow state of the stage
    logic [31:0] shadow [32];
    logic [31:0] shadow_mem [256];
    int          retired_exp = 0;
    int          credit_cnt = 0;
    int          dcredits = DMEM_CREDITS;
    int          errors = 0;
    int          timeouts = 0;

    // Expected data request of the instruction in flight
    logic        exp_mem = 1'b0;
    logic        exp_write = 1'b0;
    logic [31:0] exp_addr = '0;
    logic [31:0] exp_wdata = '0;

    core_s2_top #(
        .DMEM_CREDITS (DMEM_CREDITS)
    ) core_s2_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_in     (instr_in),
        .instr_credit (instr_credit),
        .dmem_req     (dmem_req),
        .dmem_rsp     (dmem_rsp),
        .dmem_credit  (dmem_credit),
        .cfg          (cfg),
        .status       (status)
    );

    core_s2_dmem_model dmem_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .dmem_req    (dmem_req),
        .dmem_rsp    (dmem_rsp),
        .dmem_credit (dmem_credit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Credit and request bookkeeping on the rising edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dcredits   = DMEM_CREDITS;
            credit_cnt = 0;
            exp_mem    = 1'b0;
        end else begin
            if (dmem_req.valid) begin
                dcredits = dcredits - 1;
                exp_mem  = 1'b0;
            end
            if (dmem_credit) dcredits = dcredits + 1;
            if (instr_credit) credit_cnt = credit_cnt + 1;
        end
    end

    a_req_expected: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req.valid |-> exp_mem)
    else begin
        errors++;
        $display("%0t: data request without a pending load or store", $time);
    end

    a_req_write: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req.valid |-> dmem_req.write == exp_write)
    else begin
        errors++;
        $display("FAIL %0t dmem_req.write got %b expected %b", $time,
                 $sampled(dmem_req.write), $sampled(exp_write));
    end

    a_req_addr: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req.valid |-> dmem_req.addr == exp_addr)
    else begin
        errors++;
        $display("FAIL %0t dmem_req.addr got %h expected %h", $time,
                 $sampled(dmem_req.addr), $sampled(exp_addr));
    end

    a_req_wdata: assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_req.valid && exp_write) |-> dmem_req.wdata == exp_wdata)
    else begin
        errors++;
        $display("FAIL %0t dmem_req.wdata got %h expected %h", $time,
                 $sampled(dmem_req.wdata), $sampled(exp_wdata));
    end

    a_req_credit: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req.valid |-> dcredits > 0)
    else begin
        errors++;
        $display("%0t: data request issued with no data credit left", $time);
    end

    // Never more than one instruction credit outstanding
    a_one_credit: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= 1)
    else begin
        errors++;
        $display("%0t: DUT handed out a second instruction credit", $time);
    end

    a_halt_no_credit: assert property (@(posedge clk) disable iff (!rst_n)
        status.halted |-> !instr_credit)
    else begin
        errors++;
        $display("%0t: instruction credit pulsed while halted", $time);
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Waits for a credit then presents the word for one cycle
    task automatic send_word(input logic [31:0] word, input op_e op,
                             input logic [31:0] addr, input logic [31:0] wdata);
        int n;
        if (timeouts != 0) return;
        n = 0;
        @(negedge clk);
        while (credit_cnt == 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (credit_cnt == 0) begin
            timeouts++;
            $display("%0t: timed out waiting for an instruction credit", $time);
            return;
        end
        if (exp_mem) begin
            errors++;
            $display("%0t: previous load or store never issued its request", $time);
        end
        credit_cnt = credit_cnt - 1;
        exp_mem    = (op == OP_LW) || (op == OP_SW);
        exp_write  = (op == OP_SW);
        exp_addr   = addr;
        exp_wdata  = wdata;
        if (op != OP_EBREAK && op != OP_ILLEGAL) retired_exp++;
        instr_in.valid = 1'b1;
        instr_in.word  = word;
        @(negedge clk);
        instr_in = '0;
    endtask

    task automatic write_cfg(input logic run, input logic clear_halt);
        cfg.valid      = 1'b1;
        cfg.run        = run;
        cfg.clear_halt = clear_halt;
        @(negedge clk);
        cfg = '0;
    endtask

    // Clearing the halt drops the flag and resets the cause
    task automatic restart_stage();
        write_cfg(1'b1, 1'b1);
        check_value("status.halted", 32'(status.halted), 32'd0);
        check_value("status.cause", 32'(status.cause), 32'(NONE));
    endtask

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic exec_rtype(input op_e op, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [6:0]  f7;
        logic [2:0]  f3;
        a  = shadow[rs1];
        b  = shadow[rs2];
        f7 = 7'h00;
        case (op)
            OP_SUB: begin
                f3 = 3'b000;
                f7 = 7'h20;
                r  = a - b;
            end
            OP_AND: begin
                f3 = 3'b111;
                r  = a & b;
            end
            OP_OR: begin
                f3 = 3'b110;
                r  = a | b;
            end
            OP_XOR: begin
                f3 = 3'b100;
                r  = a ^ b;
            end
            default: begin
                f3 = 3'b000;
                r  = a + b;
            end
        endcase
        if (rd != 5'd0) shadow[rd] = r;
        send_word({f7, rs2, rs1, f3, rd, 7'b0110011}, op, '0, '0);
    endtask

    task automatic exec_addi(input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [11:0] imm);
        if (rd != 5'd0) shadow[rd] = shadow[rs1] + sext12(imm);
        send_word({imm, rs1, 3'b000, rd, 7'b0010011}, OP_ADDI, '0, '0);
    endtask

    task automatic exec_lui(input logic [4:0] rd, input logic [19:0] imm);
        if (rd != 5'd0) shadow[rd] = {imm, 12'b0};
        send_word({imm, rd, 7'b0110111}, OP_LUI, '0, '0);
    endtask

    task automatic store_word(input logic [4:0] src, input logic [4:0] base,
                              input logic [11:0] offset);
        logic [31:0] addr;
        addr = shadow[base] + sext12(offset);
        shadow_mem[addr[9:2]] = shadow[src];
        send_word({offset[11:5], src, base, 3'b010, offset[4:0], 7'b0100011},
                  OP_SW, {2'b00, addr[31:2]}, shadow[src]);
    endtask

    task automatic load_word(input logic [4:0] rd, input logic [4:0] base,
                             input logic [11:0] offset);
        logic [31:0] addr;
        addr = shadow[base] + sext12(offset);
        if (rd != 5'd0) shadow[rd] = shadow_mem[addr[9:2]];
        send_word({offset, base, 3'b010, rd, 7'b0000011}, OP_LW,
                  {2'b00, addr[31:2]}, '0);
    endtask

    // Credits handed out before a halt are void
    task automatic wait_halted(input halt_cause_e cause);
        int n;
        if (timeouts != 0) return;
        n = 0;
        while (!status.halted && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!status.halted) begin
            timeouts++;
            $display("%0t: timed out waiting for the stage to halt", $time);
            return;
        end
        check_value("status.cause", 32'(status.cause), 32'(cause));
        check_value("status.retired", status.retired, 32'(retired_exp));
        credit_cnt = 0;
        repeat (4) @(negedge clk);
    endtask

    initial begin
        int i;
        void'($urandom(SEED));
        rst_n    = 1'b0;
        instr_in = '0;
        cfg      = '0;
        for (i = 0; i < 32; i++) shadow[i] = '0;
        for (i = 0; i < 256; i++) shadow_mem[i] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("dmem_req.valid", 32'(dmem_req.valid), 32'd0);
        check_value("status.halted", 32'(status.halted), 32'd0);
        check_value("status.retired", status.retired, 32'd0);
        repeat (4) @(negedge clk);
        check_value("instruction credits", 32'(credit_cnt), 32'd1);

        // First word waits in FETCH_NEXT until run is set
        exec_addi(5'd9, 5'd0, 12'h123);
        // No retire and no new credit while run is low
        repeat (4) @(negedge clk);
        check_value("instruction credits", 32'(credit_cnt), 32'd0);
        check_value("status.retired", status.retired, 32'd0);
        write_cfg(1'b1, 1'b0);

        // ALU ops made visible by the stores that follow
        exec_addi(5'd1, 5'd0, 12'($urandom));
        exec_lui(5'd2, 20'($urandom));
        exec_addi(5'd3, 5'd2, 12'($urandom));
        exec_rtype(OP_ADD, 5'd4, 5'd1, 5'd3);
        exec_rtype(OP_SUB, 5'd5, 5'd1, 5'd3);
        exec_rtype(OP_AND, 5'd6, 5'd2, 5'd3);
        exec_rtype(OP_OR,  5'd7, 5'd1, 5'd2);
        exec_rtype(OP_XOR, 5'd8, 5'd4, 5'd5);
        exec_addi(5'd0, 5'd1, 12'h7ff);
        exec_addi(5'd10, 5'd0, 12'd64);
        for (i = 1; i <= 9; i++) store_word(5'(i), 5'd10, 12'(4 * (i - 1)));
        store_word(5'd0, 5'd10, 12'd40);

        // Store then load back under random memory delays
        exec_addi(5'd11, 5'd0, 12'd128);
        for (i = 0; i < 4; i++) begin
            exec_lui(5'd12, 20'($urandom));
            exec_addi(5'd12, 5'd12, 12'($urandom));
            store_word(5'd12, 5'd11, 12'(4 * i));
        end
        for (i = 0; i < 4; i++) load_word(5'(13 + i), 5'd11, 12'(4 * i));
        for (i = 0; i < 4; i++) store_word(5'(13 + i), 5'd11, 12'(64 + 4 * i));
        load_word(5'd0, 5'd11, 12'd0);
        store_word(5'd0, 5'd11, 12'd96);

        send_word(EBREAK_WORD, OP_EBREAK, '0, '0);
        wait_halted(EBREAK);
        restart_stage();

        // All-ones word has no valid opcode
        exec_addi(5'd14, 5'd0, 12'($urandom));
        send_word(32'hffff_ffff, OP_ILLEGAL, '0, '0);
        wait_halted(ILLEGAL);
        restart_stage();
        exec_addi(5'd15, 5'd14, 12'($urandom));
        store_word(5'd15, 5'd0, 12'd16);

        // Dropping run ends in a user halt
        write_cfg(1'b0, 1'b0);
        wait_halted(USER);

        repeat (2) @(negedge clk);
        $display("Errors: %0d check, %0d timeout", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : core_s2_tb

// ==== compile.f ====
source/core_pkg.sv
source/core_decode.sv
source/core_regfile.sv
source/core_alu.sv
source/core_s2_control.sv
source/core_csr_block.sv
source/core_s2_top.sv
dv/core_s2_dmem_model.sv
dv/core_s2_tb.sv
